// ==== design/minmax_tracker.sv ====
/*
 * running min/max of the four sample channels and the sticky second mark
 * held trace entry of the last finished group
 */
`timescale 1ns/1ps

module minmax_tracker (
	input  logic                    clk,
	input  logic                    frame_start,
	input  logic                    sample_en,
	input  logic                    sec_mark,
	input  scope_pkg::sample_set_t  samples,
	output scope_pkg::trace_entry_t held
);

	localparam int SW = scope_pkg::SAMPLE_W;
	localparam int TW = scope_pkg::TRACE_W;
	localparam int CH = scope_pkg::CHANNELS;

	// channel view of the sample word, index 0 is a0
	logic [0:CH-1][SW-1:0] smp;
	logic [0:CH-1][SW-1:0] run_min;
	logic [0:CH-1][SW-1:0] run_max;
	logic                  run_mark;

	assign smp = samples;

	//////////////////////////////////////////////////
	// group accumulation
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (frame_start) begin
			// hand off the finished group, top bits only
			for (int c = 0; c < CH; c++) begin
				held.max_val[c] <= run_max[c][SW-1 -: TW];
				held.min_val[c] <= run_min[c][SW-1 -: TW];
			end
			held.mark <= run_mark;
			// next group starts from the sample on this cycle
			run_min  <= smp;
			run_max  <= smp;
			run_mark <= sec_mark;
		end else if (sample_en) begin
			// every strobed sample counts, so a one sample spike widens the band
			for (int c = 0; c < CH; c++) begin
				if (smp[c] < run_min[c]) begin
					run_min[c] <= smp[c];
				end
				if (smp[c] > run_max[c]) begin
					run_max[c] <= smp[c];
				end
			end
			// sticky, any strobe during the tick marks the column
			if (sec_mark) begin
				run_mark <= 1'b1;
			end
		end
	end

endmodule

// ==== design/pixel_render.sv ====
/*
 * raster alignment with the buffer output and window test
 * band, grid and background tests, registered color output
 */
`timescale 1ns/1ps

module pixel_render #(
	parameter int H_START  = 450,
	parameter int H_END    = 750,
	parameter int V_START  = 240,
	parameter int V_HEIGHT = 192,
	parameter scope_pkg::rgb_t GD_COLOR = 24'h32006a,
	parameter scope_pkg::rgb_t BG_COLOR = 24'h1d1d1d
) (
	input  logic                    clk,
	input  logic                    reset,
	input  scope_pkg::screen_pos_t  pos,
	input  scope_pkg::trace_entry_t entry,
	output scope_pkg::rgb_t         rgb
);

	localparam int CH = scope_pkg::CHANNELS;

	// per channel color and lift, in priority order a0 first
	localparam scope_pkg::rgb_t BAND_COLOR [CH] = '{scope_pkg::COLOR_A0,
		scope_pkg::COLOR_A1, scope_pkg::COLOR_B0, scope_pkg::COLOR_B1};
	localparam int BAND_LIFT [CH] = '{scope_pkg::LIFT_A0, scope_pkg::LIFT_A1,
		scope_pkg::LIFT_B0, scope_pkg::LIFT_B1};

	scope_pkg::screen_pos_t pos_d1;
	scope_pkg::screen_pos_t pos_d2;
	logic                   in_win;
	logic                   grid_hit;
	logic [0:CH-1]          band_hit;
	int                     row;
	scope_pkg::rgb_t        pix;

	// lit when level sits inside [lo, hi], never below zero
	function automatic logic band_lit(input logic [scope_pkg::TRACE_W-1:0] lo,
		input logic [scope_pkg::TRACE_W-1:0] hi, input int level);
		return (level >= 0) && (int'(lo) <= level) && (int'(hi) >= level);
	endfunction

	// two stages to line up with rd_addr and the buffer read
	always_ff @(posedge clk) begin
		pos_d1 <= pos;
		pos_d2 <= pos_d1;
	end

	//////////////////////////////////////////////////
	// window, band and grid tests
	//////////////////////////////////////////////////

	assign in_win = (int'(pos_d2.x) >= H_START) && (int'(pos_d2.x) <= H_END) &&
		(int'(pos_d2.y) >= V_START) && (int'(pos_d2.y) < V_START + V_HEIGHT);
	// row inside the window, 0 at the top
	assign row = int'(pos_d2.y) - V_START;
	// marker columns, or the fixed horizontal lines
	assign grid_hit = entry.mark || ((row % scope_pkg::GRID_PITCH) == scope_pkg::GRID_PHASE);

	always_comb begin
		for (int c = 0; c < CH; c++) begin
			band_hit[c] = band_lit(entry.min_val[c], entry.max_val[c], row + BAND_LIFT[c]);
		end
	end

	// lowest priority first, a0 wins last
	always_comb begin
		pix = grid_hit ? GD_COLOR : BG_COLOR;
		for (int c = CH - 1; c >= 0; c--) begin
			if (band_hit[c]) begin
				pix = BAND_COLOR[c];
			end
		end
		if (!in_win) begin
			pix = scope_pkg::COLOR_BLACK;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rgb <= scope_pkg::COLOR_BLACK;
		end else begin
			rgb <= pix;
		end
	end

endmodule

// ==== design/scope_control.sv ====
/*
 * vsync edge detect, group and second counters
 * write pointer with halt gating
 * raster counters and the scrolled read address
 */
`timescale 1ns/1ps

module scope_control #(
	parameter int H_START    = 450,
	parameter int H_END      = 750,
	parameter int N_FRAMES   = 3,
	parameter int SEC_FRAMES = 60
) (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         blank,
	input  logic                         vsync,
	input  logic                         ad_strobe,
	input  logic                         halt,
	output logic                         frame_start,
	output logic                         sample_en,
	output logic                         sec_mark,
	output logic                         wr_en,
	output logic [scope_pkg::ADDR_W-1:0] wr_addr,
	output logic [scope_pkg::ADDR_W-1:0] rd_addr,
	output scope_pkg::screen_pos_t       pos
);

	typedef logic [scope_pkg::ADDR_W-1:0] addr_t;

	localparam int GRP_W = (N_FRAMES > 1) ? $clog2(N_FRAMES) : 1;
	localparam int SEC_W = (SEC_FRAMES > 1) ? $clog2(SEC_FRAMES) : 1;
	localparam logic [GRP_W-1:0] GRP_LAST = GRP_W'(N_FRAMES - 1);
	localparam logic [SEC_W-1:0] SEC_LAST = SEC_W'(SEC_FRAMES - 1);
	// window width in columns, and its left edge on the raster
	localparam addr_t SPAN   = addr_t'(H_END - H_START);
	localparam addr_t ORIGIN = addr_t'(H_START);

	logic             vsync_d1;
	logic             blank_d1;
	logic             vs_rise;
	logic             vs_fall;
	logic             grp_zero;
	logic [GRP_W-1:0] grp_cnt;
	logic [SEC_W-1:0] sec_cnt;

	assign vs_rise  = vsync & ~vsync_d1;
	assign vs_fall  = ~vsync & vsync_d1;
	assign grp_zero = (grp_cnt == '0);
	// a second tick falls inside any group that sees count zero
	assign sec_mark = (sec_cnt == '0);
	// the sample on the restart cycle seeds the new group instead
	assign sample_en = ad_strobe & ~frame_start;

	//////////////////////////////////////////////////
	// group capture and column write
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			vsync_d1    <= 1'b0;
			grp_cnt     <= '0;
			sec_cnt     <= '0;
			frame_start <= 1'b0;
			wr_en       <= 1'b0;
			wr_addr     <= SPAN;
		end else begin
			vsync_d1    <= vsync;
			// group closes on vsync rise, lands in the buffer on the fall
			frame_start <= vs_rise & grp_zero;
			wr_en       <= vs_fall & grp_zero & ~halt;
			// pointer steps with the write strobe, so the write hits the new column
			if (vs_fall & grp_zero & ~halt) begin
				wr_addr <= wr_addr + 1'b1;
			end
			if (vs_fall) begin
				grp_cnt <= (grp_cnt == GRP_LAST) ? '0 : grp_cnt + 1'b1;
				sec_cnt <= (sec_cnt == SEC_LAST) ? '0 : sec_cnt + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// raster position and read address
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			blank_d1 <= 1'b0;
			pos      <= '0;
			rd_addr  <= '0;
		end else begin
			blank_d1 <= blank;
			pos.x    <= blank ? '0 : pos.x + 1'b1;
			// next line starts counting at the rising edge of blank
			if (vsync) begin
				pos.y <= '0;
			end else if (blank & ~blank_d1) begin
				pos.y <= pos.y + 1'b1;
			end
			// x at H_END reads the newest column, wraps mod 512
			rd_addr <= wr_addr - SPAN + pos.x[scope_pkg::ADDR_W-1:0] - ORIGIN;
		end
	end

endmodule

// ==== design/scope_pkg.sv ====
/*
 * shared widths of samples, traces, raster and buffer address
 * sample, position, trace entry and color structs
 * fixed band colors, band lifts and grid spacing
 */
package scope_pkg;

	// converter sample and stored trace value (top bits of a sample)
	localparam int SAMPLE_W = 12;
	localparam int TRACE_W  = 8;
	// raster counters and trace buffer address, 512 columns deep
	localparam int POS_W    = 10;
	localparam int ADDR_W   = 9;
	// a0, a1, b0, b1 in that order everywhere, index 0 is a0
	localparam int CHANNELS = 4;

	typedef struct packed {
		logic [SAMPLE_W-1:0] a0;
		logic [SAMPLE_W-1:0] a1;
		logic [SAMPLE_W-1:0] b0;
		logic [SAMPLE_W-1:0] b1;
	} sample_set_t;

	typedef struct packed {
		logic [POS_W-1:0] x;
		logic [POS_W-1:0] y;
	} screen_pos_t;

	// one buffer column: max of a0..b1, min of a0..b1, second mark
	typedef struct packed {
		logic [0:CHANNELS-1][TRACE_W-1:0] max_val;
		logic [0:CHANNELS-1][TRACE_W-1:0] min_val;
		logic                             mark;
	} trace_entry_t;

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb_t;

	localparam rgb_t COLOR_A0    = 24'hffffff;
	localparam rgb_t COLOR_A1    = 24'hff0000;
	localparam rgb_t COLOR_B0    = 24'h00ff00;
	localparam rgb_t COLOR_B1    = 24'h0000ff;
	localparam rgb_t COLOR_BLACK = 24'h000000;

	// band offsets in rows, full scale mode
	localparam int LIFT_A0 = 48;
	localparam int LIFT_A1 = 16;
	localparam int LIFT_B0 = -16;
	localparam int LIFT_B1 = -48;

	// horizontal grid line every 32 rows, half a pitch down
	localparam int GRID_PITCH = 32;
	localparam int GRID_PHASE = 16;

endpackage

// ==== design/tiny_scope_top.sv ====
/*
 * top level of the scrolling min/max scope
 * control, min/max tracker, trace buffer and pixel renderer
 */
`timescale 1ns/1ps

module tiny_scope_top #(
	parameter int H_START    = 450,
	parameter int H_END      = 750,
	parameter int V_START    = 240,
	parameter int V_HEIGHT   = 192,
	parameter int N_FRAMES   = 3,
	parameter int SEC_FRAMES = 60,
	parameter scope_pkg::rgb_t GD_COLOR = 24'h32006a,
	parameter scope_pkg::rgb_t BG_COLOR = 24'h1d1d1d
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   blank,
	input  logic                   vsync,
	input  scope_pkg::sample_set_t samples,
	input  logic                   ad_strobe,
	input  logic                   halt,
	output scope_pkg::rgb_t        rgb
);

	logic                         frame_start;
	logic                         sample_en;
	logic                         sec_mark;
	logic                         wr_en;
	logic [scope_pkg::ADDR_W-1:0] wr_addr;
	logic [scope_pkg::ADDR_W-1:0] rd_addr;
	scope_pkg::screen_pos_t       pos;
	scope_pkg::trace_entry_t      held;
	scope_pkg::trace_entry_t      entry;

	//////////////////////////////////////////////////
	// capture side
	//////////////////////////////////////////////////

	scope_control #(
		.H_START   (H_START),
		.H_END     (H_END),
		.N_FRAMES  (N_FRAMES),
		.SEC_FRAMES(SEC_FRAMES)
	) u_control (
		.clk        (clk),
		.reset      (reset),
		.blank      (blank),
		.vsync      (vsync),
		.ad_strobe  (ad_strobe),
		.halt       (halt),
		.frame_start(frame_start),
		.sample_en  (sample_en),
		.sec_mark   (sec_mark),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.rd_addr    (rd_addr),
		.pos        (pos)
	);

	minmax_tracker u_tracker (
		.clk        (clk),
		.frame_start(frame_start),
		.sample_en  (sample_en),
		.sec_mark   (sec_mark),
		.samples    (samples),
		.held       (held)
	);

	//////////////////////////////////////////////////
	// display side
	//////////////////////////////////////////////////

	trace_buffer u_buffer (
		.clk    (clk),
		.wr_en  (wr_en),
		.wr_addr(wr_addr),
		.held   (held),
		.rd_addr(rd_addr),
		.entry  (entry)
	);

	pixel_render #(
		.H_START (H_START),
		.H_END   (H_END),
		.V_START (V_START),
		.V_HEIGHT(V_HEIGHT),
		.GD_COLOR(GD_COLOR),
		.BG_COLOR(BG_COLOR)
	) u_render (
		.clk  (clk),
		.reset(reset),
		.pos  (pos),
		.entry(entry),
		.rgb  (rgb)
	);

endmodule

// ==== design/trace_buffer.sv ====
/*
 * simple two-port column memory of trace entries
 * synchronous write, registered read every cycle
 */
`timescale 1ns/1ps

module trace_buffer (
	input  logic                         clk,
	input  logic                         wr_en,
	input  logic [scope_pkg::ADDR_W-1:0] wr_addr,
	input  scope_pkg::trace_entry_t      held,
	input  logic [scope_pkg::ADDR_W-1:0] rd_addr,
	output scope_pkg::trace_entry_t      entry
);

	localparam int DEPTH = 2 ** scope_pkg::ADDR_W;

	// one entry per captured group
	scope_pkg::trace_entry_t mem [DEPTH];

	// write port, one column per group
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= held;
		end
	end

	// read port follows the raster, a new column every pixel
	always_ff @(posedge clk) begin
		entry <= mem[rd_addr];
	end

endmodule

// ==== dv/tb_tiny_scope.sv ====
/*
 * testbench for the scrolling min/max scope
 * small raster, xorshift samples with spikes, halt window
 * column and pixel model with a 3-cycle output offset, watchdog
 */
`timescale 1ns/1ps

module tb_tiny_scope;

	localparam int H_START    = 8;
	localparam int H_END      = 39;
	localparam int V_START    = 24;
	localparam int V_HEIGHT   = 192;
	localparam int N_FRAMES   = 2;
	localparam int SEC_FRAMES = 3;
	localparam scope_pkg::rgb_t GD_COLOR = 24'h32006a;
	localparam scope_pkg::rgb_t BG_COLOR = 24'h1d1d1d;
	// 48 active + 8 blank cycles a line, 240 lines then 4 vsync lines
	localparam int ACTIVE     = 48;
	localparam int LINE_CYC   = 56;
	localparam int LINES      = 240;
	localparam int FRAME_CYC  = LINE_CYC * (LINES + 4);
	localparam int NUM_FRAMES = 24;
	localparam int HALT_FIRST = 10;
	localparam int HALT_LAST  = 15;
	localparam int DEPTH      = 2 ** scope_pkg::ADDR_W;
	localparam time WATCHDOG_NS = 2 * 8 * (8 + NUM_FRAMES * FRAME_CYC + 8);
	// band order is the priority order
	localparam scope_pkg::rgb_t BAND_COLOR [4] = '{scope_pkg::COLOR_A0,
		scope_pkg::COLOR_A1, scope_pkg::COLOR_B0, scope_pkg::COLOR_B1};
	localparam int BAND_LIFT [4] = '{scope_pkg::LIFT_A0, scope_pkg::LIFT_A1,
		scope_pkg::LIFT_B0, scope_pkg::LIFT_B1};

	// one predicted pixel, waiting for the output pipeline
	typedef struct packed {
		scope_pkg::rgb_t color;
		logic            ok;
		logic            win;
		logic            mark;
		logic [9:0]      x;
		logic [9:0]      y;
	} expect_t;

	logic                   clk;
	logic                   reset;
	logic                   blank;
	logic                   vsync;
	logic                   ad_strobe;
	logic                   halt;
	scope_pkg::sample_set_t samples;
	scope_pkg::rgb_t        rgb;

	// model of counters, group tracking and committed columns
	logic        m_vs_d;
	logic        m_bl_d;
	logic        m_fs;
	int          m_grp;
	int          m_sec;
	logic [8:0]  m_wr;
	logic [9:0]  m_x;
	logic [9:0]  m_y;
	logic [11:0] run_min [4];
	logic [11:0] run_max [4];
	logic        run_mark;
	logic        run_ok = 1'b0;
	logic [7:0]  held_min [4];
	logic [7:0]  held_max [4];
	logic        held_mark;
	logic        held_ok = 1'b0;
	logic [7:0]  col_min [DEPTH][4];
	logic [7:0]  col_max [DEPTH][4];
	logic        col_mark [DEPTH];
	logic        col_ok [DEPTH] = '{default: 1'b0};
	expect_t     pending [$];
	logic [31:0] rng = 32'd38527;
	logic [11:0] base [4];
	int          n_win = 0;
	int          n_mark = 0;

	tiny_scope_top #(
		.H_START   (H_START),
		.H_END     (H_END),
		.V_START   (V_START),
		.V_HEIGHT  (V_HEIGHT),
		.N_FRAMES  (N_FRAMES),
		.SEC_FRAMES(SEC_FRAMES),
		.GD_COLOR  (GD_COLOR),
		.BG_COLOR  (BG_COLOR)
	) UUT (
		.clk      (clk),
		.reset    (reset),
		.blank    (blank),
		.vsync    (vsync),
		.samples  (samples),
		.ad_strobe(ad_strobe),
		.halt     (halt),
		.rgb      (rgb)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] v;
		v = s ^ (s << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	function logic [31:0] next_rand();
		rng = xorshift32(rng);
		return rng;
	endfunction

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("ERR %s expected %h actual %h", name, expected, actual);
			$display("Result: FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// advance the model by the clock edge that just consumed the inputs
	task automatic model_step();
		logic [11:0] s [4];
		logic        rise;
		logic        fall;
		s = '{samples.a0, samples.a1, samples.b0, samples.b1};
		if (reset) begin
			m_vs_d = 1'b0;
			m_bl_d = 1'b0;
			m_fs   = 1'b0;
			m_grp  = 0;
			m_sec  = 0;
			m_wr   = 9'(H_END - H_START);
			m_x    = '0;
			m_y    = '0;
		end else begin
			rise = vsync & ~m_vs_d;
			fall = ~vsync & m_vs_d;
			if (m_fs) begin
				// finished group moves to held, next group seeded by this sample
				for (int c = 0; c < 4; c++) begin
					held_min[c] = run_min[c][11:4];
					held_max[c] = run_max[c][11:4];
					run_min[c]  = s[c];
					run_max[c]  = s[c];
				end
				held_mark = run_mark;
				held_ok   = run_ok;
				run_mark  = (m_sec == 0);
				run_ok    = 1'b1;
			end else if (ad_strobe) begin
				for (int c = 0; c < 4; c++) begin
					if (s[c] < run_min[c]) run_min[c] = s[c];
					if (s[c] > run_max[c]) run_max[c] = s[c];
				end
				if (m_sec == 0) run_mark = 1'b1;
			end
			m_fs = rise && (m_grp == 0);
			// commit on the fall, at the stepped pointer
			if (fall && (m_grp == 0) && !halt) begin
				m_wr = m_wr + 1'b1;
				for (int c = 0; c < 4; c++) begin
					col_min[m_wr][c] = held_min[c];
					col_max[m_wr][c] = held_max[c];
				end
				col_mark[m_wr] = held_mark;
				col_ok[m_wr]   = held_ok;
			end
			if (fall) begin
				m_grp = (m_grp + 1) % N_FRAMES;
				m_sec = (m_sec + 1) % SEC_FRAMES;
			end
			m_x = blank ? '0 : m_x + 1'b1;
			if (vsync) m_y = '0;
			else if (blank && !m_bl_d) m_y = m_y + 1'b1;
			m_vs_d = vsync;
			m_bl_d = blank;
		end
	endtask

	// color rule for one raster position, using the current columns
	function automatic expect_t expect_pixel(input logic [9:0] x, input logic [9:0] y);
		expect_t    e;
		logic [8:0] col;
		int         row;
		int         level;
		logic       found;
		e       = '0;
		e.x     = x;
		e.y     = y;
		e.ok    = 1'b1;
		e.color = scope_pkg::COLOR_BLACK;
		e.win   = (x >= H_START) && (x <= H_END) && (y >= V_START) && (y < V_START + V_HEIGHT);
		if (e.win) begin
			// newest column at the right edge, older ones to its left
			col    = m_wr - 9'(H_END - H_START) + 9'(x - H_START);
			row    = int'(y) - V_START;
			e.ok   = col_ok[col];
			e.mark = col_mark[col];
			found  = 1'b0;
			for (int c = 0; c < 4; c++) begin
				level = row + BAND_LIFT[c];
				if (!found && level >= 0 && level >= int'(col_min[col][c]) &&
					level <= int'(col_max[col][c])) begin
					e.color = BAND_COLOR[c];
					found   = 1'b1;
				end
			end
			if (!found) begin
				e.color = (e.mark || (row % scope_pkg::GRID_PITCH == scope_pkg::GRID_PHASE)) ?
					GD_COLOR : BG_COLOR;
			end
		end
		return e;
	endfunction

	// one clock: update model, check the pixel from 3 cycles back, drive inputs
	task automatic tick(input logic rst, input logic bl, input logic vs);
		expect_t     p;
		logic [31:0] r;
		logic [11:0] v [4];
		@(negedge clk);
		model_step();
		pending.push_back(expect_pixel(m_x, m_y));
		if (pending.size() > 3) begin
			p = pending.pop_front();
			if (p.ok) begin
				if (p.win) n_win++;
				if (p.win && p.mark) n_mark++;
				check($sformatf("%s x=%0d y=%0d", p.win ? "window_pixel" : "black_pixel",
					p.x, p.y), {8'h00, p.color}, {8'h00, rgb});
			end
		end
		r = next_rand();
		for (int c = 0; c < 4; c++) begin
			v[c] = base[c] + 12'(next_rand() & 32'h3f);
		end
		// rare one-sample spike on one channel, strobed or not
		if (r[21:8] == '0) v[r[23:22]] = {r[31:24], 4'h0};
		reset      = rst;
		blank      = bl;
		vsync      = vs;
		ad_strobe  = r[0];
		samples.a0 = v[0];
		samples.a1 = v[1];
		samples.b0 = v[2];
		samples.b1 = v[3];
	endtask

	//////////////////////////////////////////////////
	// stimulus and watchdog
	//////////////////////////////////////////////////

	initial begin
		reset     = 1'b1;
		blank     = 1'b1;
		vsync     = 1'b0;
		ad_strobe = 1'b0;
		halt      = 1'b0;
		samples   = '0;
		base      = '{default: 12'h000};
		repeat (7) tick(1'b1, 1'b1, 1'b0);
		for (int f = 0; f < NUM_FRAMES; f++) begin
			// halt covers several whole frames, columns freeze meanwhile
			halt = (f >= HALT_FIRST) && (f <= HALT_LAST);
			for (int c = 0; c < 4; c++) begin
				base[c] = 12'(next_rand() % 4032);
			end
			for (int l = 0; l < LINES + 4; l++) begin
				for (int cyc = 0; cyc < LINE_CYC; cyc++) begin
					tick(1'b0, (l >= LINES) || (cyc >= ACTIVE), l >= LINES);
				end
			end
		end
		repeat (8) tick(1'b0, 1'b1, 1'b0);
		check("window_pixels_checked", 1, n_win > 0);
		check("marked_pixels_checked", 1, n_mark > 0);
		$display("Result: PASSED");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the last frame was finished");
		$display("Result: FAILED");
		$fatal(1, "simulation timed out");
	end

endmodule

// ==== dv/tiny_scope_properties.sv ====
/*
 * concurrent assertions on the scope controller
 * halt gating, single-cycle frame_start, write pointer stepping
 */
`timescale 1ns/1ps

module scope_control_properties (
	input logic                         clk,
	input logic                         reset,
	input logic                         halt,
	input logic                         frame_start,
	input logic                         wr_en,
	input logic [scope_pkg::ADDR_W-1:0] wr_addr
);

	// a halted fall never commits a column
	a_halt_blocks_write: assert property (@(posedge clk) disable iff (reset)
		$past(halt) |-> !wr_en)
		else $error("column written although halt was high");

	// group restart is a pulse
	a_frame_start_pulse: assert property (@(posedge clk) disable iff (reset)
		frame_start |=> !frame_start)
		else $error("frame_start high on two cycles in a row");

	// pointer and write strobe are registered together
	a_pointer_with_write: assert property (@(posedge clk) disable iff (reset)
		$changed(wr_addr) |-> wr_en)
		else $error("write pointer moved without a write");

endmodule

bind scope_control scope_control_properties u_props (
	.clk        (clk),
	.reset      (reset),
	.halt       (halt),
	.frame_start(frame_start),
	.wr_en      (wr_en),
	.wr_addr    (wr_addr)
);

// ==== tiny_scope.f ====
design/scope_pkg.sv
design/scope_control.sv
design/minmax_tracker.sv
design/trace_buffer.sv
design/pixel_render.sv
design/tiny_scope_top.sv
dv/tiny_scope_properties.sv
dv/tb_tiny_scope.sv
